/* logic/core_demux_defs.svh */
`ifndef CORE_DEMUX_DEFS_SVH
`define CORE_DEMUX_DEFS_SVH

// Core data bus
`define CD_ADDR_W        32
`define CD_DATA_W        32
`define CD_BE_W          4

// Memory map
`define CD_REGION_HI     31
`define CD_REGION_LO     20
`define CD_TCDM_BASE     12'h100  // Region of cluster 0
`define CD_EXT_SEL_BIT   14       // Demux peripherals inside the periph region
`define CD_CLUSTER_ID_W  6

// Peripheral path
`define CD_FIFO_DEPTH    2

`endif

/* logic/demux_map_pkg.sv */
`include "core_demux_defs.svh"

package demux_map_pkg;

  // Where a core access ends up
  typedef enum logic [1:0] {
    SH  = 2'd0,  // Cluster TCDM
    PE  = 2'd1,  // Peripheral interconnect
    EXT = 2'd2   // Demux peripherals
  } dest_e;

  // Top address bits, one region per MiB
  typedef logic [`CD_REGION_HI-`CD_REGION_LO:0] region_t;

endpackage

/* logic/demux_bus_pkg.sv */
`include "core_demux_defs.svh"

package demux_bus_pkg;

  // Request as it sits in the peripheral FIFO
  typedef struct packed {
    logic [`CD_ADDR_W-1:0] addr;
    logic                  wen;    // Low for a store
    logic [`CD_DATA_W-1:0] wdata;
    logic [`CD_BE_W-1:0]   be;
  } periph_req_t;

  typedef struct packed {
    logic [`CD_DATA_W-1:0] rdata;
    logic                  opc;    // Error flag
  } periph_resp_t;

  // One peripheral transaction in flight at most
  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    PENDING = 2'd1,
    GRANTED = 2'd2
  } pe_state_e;

endpackage

/* logic/addr_decoder.sv */
`timescale 1ns/1ps
`include "core_demux_defs.svh"

module addr_decoder (
  input  logic                        clk,
  input  logic                        rst_ni,
  input  logic                        req_i,
  input  logic [`CD_ADDR_W-1:0]       addr_i,
  input  logic [`CD_CLUSTER_ID_W-1:0] cluster_id_i,
  output demux_map_pkg::dest_e        dest_o,
  output demux_map_pkg::dest_e        resp_dest_o
);

  import demux_map_pkg::*;

  localparam int RegionW = `CD_REGION_HI - `CD_REGION_LO + 1;
  localparam int PadW    = RegionW - `CD_CLUSTER_ID_W - 2;

  region_t region;
  region_t tcdm_rw;  // First TCDM region of this cluster
  region_t tcdm_ts;  // Test-and-set alias
  region_t dem_per;  // Shared by PE and EXT

  assign region = addr_i[`CD_REGION_HI:`CD_REGION_LO];

  // Each cluster owns four consecutive regions
  assign tcdm_rw = `CD_TCDM_BASE + {{PadW{1'b0}}, cluster_id_i, 2'b00};
  assign tcdm_ts = tcdm_rw + region_t'(1);
  assign dem_per = tcdm_rw + region_t'(2);

  always_comb begin
    if (region == tcdm_rw || region == tcdm_ts) begin
      dest_o = SH;
    end else if (region == dem_per) begin
      dest_o = addr_i[`CD_EXT_SEL_BIT] ? EXT : PE;
    end else begin
      dest_o = PE;  // Everything else, other clusters included
    end
  end

  // Remember who owes the next response
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      resp_dest_o <= SH;
    end else if (req_i) begin
      resp_dest_o <= dest_o;
    end
  end

endmodule

/* logic/req_router.sv */
`timescale 1ns/1ps
`include "core_demux_defs.svh"

module req_router (
  input  logic                        req_i,
  input  demux_map_pkg::dest_e        dest_i,
  input  demux_map_pkg::dest_e        resp_dest_i,
  input  logic                        sh_gnt_i,
  input  logic                        ext_gnt_i,
  input  logic                        pe_gnt_i,
  input  logic                        sh_r_valid_i,
  input  logic [`CD_DATA_W-1:0]       sh_r_rdata_i,
  input  logic                        ext_r_valid_i,
  input  logic [`CD_DATA_W-1:0]       ext_r_rdata_i,
  input  logic                        ext_r_opc_i,
  input  logic                        pe_r_valid_i,
  input  demux_bus_pkg::periph_resp_t pe_r_resp_i,
  output logic                        sh_req_o,
  output logic                        ext_req_o,
  output logic                        pe_req_o,
  output logic                        gnt_o,
  output logic                        r_valid_o,
  output logic [`CD_DATA_W-1:0]       r_rdata_o,
  output logic                        r_opc_o
);

  import demux_map_pkg::*;
  import demux_bus_pkg::*;

  // Request steering, one strobe at a time
  always_comb begin
    sh_req_o  = 1'b0;
    ext_req_o = 1'b0;
    pe_req_o  = 1'b0;
    gnt_o     = 1'b0;
    case (dest_i)
      SH: begin
        sh_req_o = req_i;
        gnt_o    = req_i & sh_gnt_i;
      end
      EXT: begin
        ext_req_o = req_i;
        gnt_o     = req_i & ext_gnt_i;
      end
      PE: begin
        pe_req_o = req_i;
        gnt_o    = req_i & pe_gnt_i;  // From the transaction controller
      end
      default: ;
    endcase
  end

  // Response return follows the registered destination
  always_comb begin
    case (resp_dest_i)
      SH: begin
        r_valid_o = sh_r_valid_i;
        r_rdata_o = sh_r_rdata_i;
        r_opc_o   = 1'b0;  // TCDM never flags an error
      end
      EXT: begin
        r_valid_o = ext_r_valid_i;
        r_rdata_o = ext_r_rdata_i;
        r_opc_o   = ext_r_opc_i;
      end
      PE: begin
        r_valid_o = pe_r_valid_i;
        r_rdata_o = pe_r_resp_i.rdata;
        r_opc_o   = pe_r_resp_i.opc;
      end
      default: begin
        r_valid_o = 1'b0;
        r_rdata_o = '0;
        r_opc_o   = 1'b0;
      end
    endcase
  end

endmodule

/* logic/periph_fifo.sv */
`timescale 1ns/1ps
`include "core_demux_defs.svh"

module periph_fifo (
  input  logic                       clk,
  input  logic                       rst_ni,
  input  logic                       push_i,
  input  demux_bus_pkg::periph_req_t push_data_i,
  input  logic                       pe_gnt_i,
  output logic                       push_gnt_o,
  output logic                       pe_req_o,
  output demux_bus_pkg::periph_req_t pe_data_o
);

  import demux_bus_pkg::*;

  localparam int Depth = `CD_FIFO_DEPTH;
  localparam int PtrW  = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntW  = $clog2(Depth + 1);

  periph_req_t       mem_q [Depth];
  logic [PtrW-1:0]   wr_ptr_q;
  logic [PtrW-1:0]   rd_ptr_q;
  logic [CntW-1:0]   count_q;
  logic              push;
  logic              pop;

  assign push_gnt_o = (count_q != CntW'(Depth));  // Room for one more
  assign pe_req_o   = (count_q != '0);
  assign pe_data_o  = mem_q[rd_ptr_q];

  assign push = push_i & push_gnt_o;
  assign pop  = pe_req_o & pe_gnt_i;

  always_ff @(posedge clk) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop leaves the count alone
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

/* logic/periph_txn_ctrl.sv */
`timescale 1ns/1ps

module periph_txn_ctrl (
  input  logic                        clk,
  input  logic                        rst_ni,
  input  logic                        pe_req_i,
  input  logic                        fifo_gnt_i,
  input  logic                        pe_r_valid_i,
  input  demux_bus_pkg::periph_resp_t pe_r_resp_i,
  output logic                        fifo_push_o,
  output logic                        core_gnt_o,
  output logic                        resp_valid_o,
  output demux_bus_pkg::periph_resp_t resp_o
);

  import demux_bus_pkg::*;

  pe_state_e    state_q;
  pe_state_e    state_d;

  // Response delay line
  logic         valid0_q;
  logic         valid1_q;
  periph_resp_t resp0_q;
  periph_resp_t resp1_q;

  always_comb begin
    state_d     = state_q;
    fifo_push_o = 1'b0;
    core_gnt_o  = 1'b0;
    case (state_q)
      IDLE: begin
        fifo_push_o = pe_req_i;
        if (pe_req_i && fifo_gnt_i) begin
          state_d = PENDING;
        end
      end
      PENDING: begin
        if (pe_r_valid_i) begin
          state_d = GRANTED;  // Response is on its way
        end
      end
      GRANTED: begin
        core_gnt_o = 1'b1;
        state_d    = IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= IDLE;
      valid0_q <= 1'b0;
      valid1_q <= 1'b0;
    end else begin
      state_q  <= state_d;
      valid0_q <= pe_r_valid_i;
      valid1_q <= valid0_q;
    end
  end

  // Payload stages only move with their valid
  always_ff @(posedge clk) begin
    if (pe_r_valid_i) begin
      resp0_q <= pe_r_resp_i;
    end
    if (valid0_q) begin
      resp1_q <= resp0_q;
    end
  end

  assign resp_valid_o = valid1_q;  // One cycle after core_gnt_o
  assign resp_o       = resp1_q;

endmodule

/* logic/core_demux.sv */
`timescale 1ns/1ps
`include "core_demux_defs.svh"

module core_demux (
  input  logic                        clk,
  input  logic                        rst_ni,
  input  logic [`CD_CLUSTER_ID_W-1:0] cluster_id_i,
  // Core side
  input  logic                        data_req_i,
  input  logic [`CD_ADDR_W-1:0]       data_add_i,
  input  logic                        data_wen_i,
  input  logic [`CD_DATA_W-1:0]       data_wdata_i,
  input  logic [`CD_BE_W-1:0]         data_be_i,
  output logic                        data_gnt_o,
  output logic                        data_r_valid_o,
  output logic [`CD_DATA_W-1:0]       data_r_rdata_o,
  output logic                        data_r_opc_o,
  // Cluster TCDM
  output logic                        sh_req_o,
  output logic [`CD_ADDR_W-1:0]       sh_addr_o,
  output logic                        sh_wen_o,
  output logic [`CD_DATA_W-1:0]       sh_wdata_o,
  output logic [`CD_BE_W-1:0]         sh_be_o,
  input  logic                        sh_gnt_i,
  input  logic                        sh_r_valid_i,
  input  logic [`CD_DATA_W-1:0]       sh_r_rdata_i,
  // Demux peripherals
  output logic                        ext_req_o,
  output logic [`CD_ADDR_W-1:0]       ext_addr_o,
  output logic                        ext_wen_o,
  output logic [`CD_DATA_W-1:0]       ext_wdata_o,
  output logic [`CD_BE_W-1:0]         ext_be_o,
  input  logic                        ext_gnt_i,
  input  logic                        ext_r_valid_i,
  input  logic [`CD_DATA_W-1:0]       ext_r_rdata_i,
  input  logic                        ext_r_opc_i,
  // Peripheral interconnect
  output logic                        pe_req_o,
  output logic [`CD_ADDR_W-1:0]       pe_addr_o,
  output logic                        pe_wen_o,
  output logic [`CD_DATA_W-1:0]       pe_wdata_o,
  output logic [`CD_BE_W-1:0]         pe_be_o,
  input  logic                        pe_gnt_i,
  input  logic                        pe_r_valid_i,
  input  logic [`CD_DATA_W-1:0]       pe_r_rdata_i,
  input  logic                        pe_r_opc_i
);

  import demux_map_pkg::*;
  import demux_bus_pkg::*;

  dest_e        dest;
  dest_e        resp_dest;
  logic         pe_req;       // Core request aimed at PE
  logic         pe_core_gnt;
  logic         fifo_push;
  logic         fifo_gnt;
  logic         pe_resp_valid;
  periph_resp_t pe_resp;      // Delayed response
  periph_resp_t pe_r_in;
  periph_req_t  fifo_in;
  periph_req_t  fifo_out;

  // SH and EXT see the core bus directly
  assign sh_addr_o   = data_add_i;
  assign sh_wen_o    = data_wen_i;
  assign sh_wdata_o  = data_wdata_i;
  assign sh_be_o     = data_be_i;
  assign ext_addr_o  = data_add_i;
  assign ext_wen_o   = data_wen_i;
  assign ext_wdata_o = data_wdata_i;
  assign ext_be_o    = data_be_i;

  assign fifo_in = '{addr: data_add_i, wen: data_wen_i, wdata: data_wdata_i, be: data_be_i};
  assign pe_r_in = '{rdata: pe_r_rdata_i, opc: pe_r_opc_i};

  assign pe_addr_o  = fifo_out.addr;
  assign pe_wen_o   = fifo_out.wen;
  assign pe_wdata_o = fifo_out.wdata;
  assign pe_be_o    = fifo_out.be;

  addr_decoder i_addr_decoder (
    .clk          ( clk          ),
    .rst_ni       ( rst_ni       ),
    .req_i        ( data_req_i   ),
    .addr_i       ( data_add_i   ),
    .cluster_id_i ( cluster_id_i ),
    .dest_o       ( dest         ),
    .resp_dest_o  ( resp_dest    )
  );

  req_router i_req_router (
    .req_i         ( data_req_i     ),
    .dest_i        ( dest           ),
    .resp_dest_i   ( resp_dest      ),
    .sh_gnt_i      ( sh_gnt_i       ),
    .ext_gnt_i     ( ext_gnt_i      ),
    .pe_gnt_i      ( pe_core_gnt    ),
    .sh_r_valid_i  ( sh_r_valid_i   ),
    .sh_r_rdata_i  ( sh_r_rdata_i   ),
    .ext_r_valid_i ( ext_r_valid_i  ),
    .ext_r_rdata_i ( ext_r_rdata_i  ),
    .ext_r_opc_i   ( ext_r_opc_i    ),
    .pe_r_valid_i  ( pe_resp_valid  ),
    .pe_r_resp_i   ( pe_resp        ),
    .sh_req_o      ( sh_req_o       ),
    .ext_req_o     ( ext_req_o      ),
    .pe_req_o      ( pe_req         ),
    .gnt_o         ( data_gnt_o     ),
    .r_valid_o     ( data_r_valid_o ),
    .r_rdata_o     ( data_r_rdata_o ),
    .r_opc_o       ( data_r_opc_o   )
  );

  periph_txn_ctrl i_periph_txn_ctrl (
    .clk          ( clk           ),
    .rst_ni       ( rst_ni        ),
    .pe_req_i     ( pe_req        ),
    .fifo_gnt_i   ( fifo_gnt      ),
    .pe_r_valid_i ( pe_r_valid_i  ),
    .pe_r_resp_i  ( pe_r_in       ),
    .fifo_push_o  ( fifo_push     ),
    .core_gnt_o   ( pe_core_gnt   ),
    .resp_valid_o ( pe_resp_valid ),
    .resp_o       ( pe_resp       )
  );

  periph_fifo i_periph_fifo (
    .clk         ( clk       ),
    .rst_ni      ( rst_ni    ),
    .push_i      ( fifo_push ),
    .push_data_i ( fifo_in   ),
    .pe_gnt_i    ( pe_gnt_i  ),
    .push_gnt_o  ( fifo_gnt  ),
    .pe_req_o    ( pe_req_o  ),
    .pe_data_o   ( fifo_out  )
  );

endmodule

/* dv/core_demux_sva.sv */
`timescale 1ns/1ps
`include "core_demux_defs.svh"

module core_demux_sva (
  input logic                  clk,
  input logic                  rst_ni,
  input logic                  sh_req_i,
  input logic                  ext_req_i,
  input logic                  pe_req_i,
  input logic [`CD_ADDR_W-1:0] pe_addr_i,
  input logic                  pe_gnt_i,
  input logic                  pe_core_gnt_i,
  input logic                  r_valid_i
);

  // The core talks to one target at a time
  a_one_target: assert property (@(posedge clk) disable iff (!rst_ni)
    $onehot0({sh_req_i, ext_req_i, pe_req_i}))
    else $error("more than one target request high");

  a_pe_resp: assert property (@(posedge clk) disable iff (!rst_ni)
    pe_core_gnt_i |=> r_valid_i)  // Two-stage delay line
    else $error("no core response one cycle after the PE grant");

  // Waiting request keeps its address until the interconnect takes it
  a_pe_hold: assert property (@(posedge clk) disable iff (!rst_ni)
    pe_req_i && !pe_gnt_i |=> pe_req_i && $stable(pe_addr_i))
    else $error("PE request dropped or changed before its grant");

endmodule

bind core_demux core_demux_sva i_core_demux_sva (
  .clk           ( clk            ),
  .rst_ni        ( rst_ni         ),
  .sh_req_i      ( sh_req_o       ),
  .ext_req_i     ( ext_req_o      ),
  .pe_req_i      ( pe_req_o       ),
  .pe_addr_i     ( pe_addr_o      ),
  .pe_gnt_i      ( pe_gnt_i       ),
  .pe_core_gnt_i ( pe_core_gnt    ),
  .r_valid_i     ( data_r_valid_o )
);

/* dv/core_demux_tb.sv */
`timescale 1ns/1ps
`include "core_demux_defs.svh"

module core_demux_tb;

  import demux_map_pkg::*;

  localparam int ClkPeriod = 8;
  localparam int NumRows   = 14;
  localparam int BusW      = `CD_ADDR_W + `CD_DATA_W + `CD_BE_W + 1;

  typedef struct packed {
    logic [`CD_ADDR_W-1:0]       addr;
    logic                        wen;
    logic [`CD_DATA_W-1:0]       wdata;
    logic [`CD_BE_W-1:0]         be;
    dest_e                       dest;  // Worked out by hand from the memory map
    logic [`CD_CLUSTER_ID_W-1:0] cid;
  } row_t;

  localparam row_t Rows [NumRows] = '{
    '{32'h1000_0010, 1'b1, 32'h0000_0000, 4'hF, SH,  6'd0},
    '{32'h1010_0024, 1'b0, 32'hDEAD_BEEF, 4'h3, SH,  6'd0},  // Test-and-set alias
    '{32'h1020_4008, 1'b1, 32'h0000_0000, 4'hF, EXT, 6'd0},
    '{32'h1020_0008, 1'b0, 32'h1234_5678, 4'hC, PE,  6'd0},  // Three PE rows in a row
    '{32'h1020_000C, 1'b1, 32'h0000_0000, 4'hF, PE,  6'd0},
    '{32'h1A00_0100, 1'b1, 32'h0000_0000, 4'h1, PE,  6'd0},
    '{32'h10C0_0004, 1'b1, 32'h0000_0000, 4'hF, SH,  6'd3},
    '{32'h1000_0004, 1'b0, 32'h0BAD_F00D, 4'hF, PE,  6'd3},  // TCDM of cluster 0
    '{32'h10E0_4004, 1'b0, 32'hCAFE_F00D, 4'h5, EXT, 6'd3},
    '{32'h10D0_0040, 1'b1, 32'h0000_0000, 4'hF, SH,  6'd3},
    '{32'h10E0_0010, 1'b1, 32'h0000_0000, 4'hF, PE,  6'd3},
    '{32'h1150_0008, 1'b0, 32'h5555_AAAA, 4'hA, SH,  6'd5},
    '{32'h1160_4000, 1'b1, 32'h0000_0000, 4'hF, EXT, 6'd5},
    '{32'h10C0_000C, 1'b1, 32'h0000_0000, 4'hF, PE,  6'd5}   // TCDM of cluster 3
  };

  logic clk = 1'b0;
  logic rst_ni;
  logic [`CD_CLUSTER_ID_W-1:0] cluster_id;
  logic data_req, data_wen, data_gnt_o, data_r_valid_o, data_r_opc_o;
  logic [`CD_ADDR_W-1:0] data_add;
  logic [`CD_DATA_W-1:0] data_wdata, data_r_rdata_o;
  logic [`CD_BE_W-1:0] data_be;
  logic sh_req_o, sh_wen_o, ext_req_o, ext_wen_o, pe_req_o, pe_wen_o;
  logic [`CD_ADDR_W-1:0] sh_addr_o, ext_addr_o, pe_addr_o;
  logic [`CD_DATA_W-1:0] sh_wdata_o, ext_wdata_o, pe_wdata_o;
  logic [`CD_BE_W-1:0] sh_be_o, ext_be_o, pe_be_o;

  // Target model state, inputs start idle
  logic sh_gnt = 1'b0, sh_r_valid = 1'b0, sh_rsp = 1'b0;
  logic ext_gnt = 1'b0, ext_r_valid = 1'b0, ext_r_opc = 1'b0, ext_rsp = 1'b0;
  logic pe_gnt = 1'b0, pe_r_valid = 1'b0, pe_r_opc = 1'b0, pe_rsp = 1'b0;
  logic [`CD_DATA_W-1:0] sh_r_rdata = '0, ext_r_rdata = '0, pe_r_rdata = '0;
  logic [`CD_ADDR_W-1:0] sh_last = '0, ext_last = '0, pe_last = '0;
  int unsigned sh_cnt = 0, ext_cnt = 0, pe_cnt = 0;
  int unsigned sh_dly = 1, ext_dly = 0, pe_dly = 3;

  dest_e       cur_dest = SH;
  logic        pe_gnt_q = 1'b0;
  logic [32:0] exp_q [$];  // {opc, rdata} in grant order

  always #(ClkPeriod / 2) clk = ~clk;

  core_demux i_core_demux (
    .clk, .rst_ni, .cluster_id_i(cluster_id),
    .data_req_i(data_req), .data_add_i(data_add), .data_wen_i(data_wen),
    .data_wdata_i(data_wdata), .data_be_i(data_be), .data_gnt_o, .data_r_valid_o,
    .data_r_rdata_o, .data_r_opc_o,
    .sh_req_o, .sh_addr_o, .sh_wen_o, .sh_wdata_o, .sh_be_o, .sh_gnt_i(sh_gnt),
    .sh_r_valid_i(sh_r_valid), .sh_r_rdata_i(sh_r_rdata),
    .ext_req_o, .ext_addr_o, .ext_wen_o, .ext_wdata_o, .ext_be_o, .ext_gnt_i(ext_gnt),
    .ext_r_valid_i(ext_r_valid), .ext_r_rdata_i(ext_r_rdata), .ext_r_opc_i(ext_r_opc),
    .pe_req_o, .pe_addr_o, .pe_wen_o, .pe_wdata_o, .pe_be_o, .pe_gnt_i(pe_gnt),
    .pe_r_valid_i(pe_r_valid), .pe_r_rdata_i(pe_r_rdata), .pe_r_opc_i(pe_r_opc)
  );

  task automatic check_eq(input logic [BusW-1:0] got, input logic [BusW-1:0] exp,
                          input string msg);
    if (got !== exp) begin
      $display("Error: %0t ns: %s: got %0h, expected %0h", $time, msg, got, exp);
      $display("tests failed");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  function automatic logic [32:0] expected_resp(dest_e dest, logic [31:0] addr);
    case (dest)
      SH:      return {1'b0, addr ^ 32'h5A5A_5A5A};
      EXT:     return {addr[2], addr ^ 32'hE0E0_E0E0};
      default: return {addr[3], ~addr};
    endcase
  endfunction

  // Models grant after a drawn delay and answer one cycle after the grant
  always @(posedge clk) begin
    sh_rsp   <= rst_ni && sh_req_o && sh_gnt;
    ext_rsp  <= rst_ni && ext_req_o && ext_gnt;
    pe_rsp   <= rst_ni && pe_req_o && pe_gnt;
    sh_last  <= sh_addr_o;
    ext_last <= ext_addr_o;
    pe_last  <= pe_addr_o;
    if (sh_req_o && sh_gnt) begin
      sh_cnt <= 0;
      sh_dly <= $urandom_range(2, 0);
    end else if (sh_req_o) begin
      sh_cnt <= sh_cnt + 1;
    end
    if (ext_req_o && ext_gnt) begin
      ext_cnt <= 0;
      ext_dly <= $urandom_range(2, 0);
    end else if (ext_req_o) begin
      ext_cnt <= ext_cnt + 1;
    end
    if (pe_req_o && pe_gnt) begin
      pe_cnt <= 0;
      pe_dly <= $urandom_range(5, 2);  // Slow interconnect
    end else if (pe_req_o) begin
      pe_cnt <= pe_cnt + 1;
    end
  end

  always @(negedge clk) begin
    sh_gnt      <= sh_cnt >= sh_dly;
    sh_r_valid  <= sh_rsp;
    sh_r_rdata  <= sh_last ^ 32'h5A5A_5A5A;
    ext_gnt     <= ext_cnt >= ext_dly;
    ext_r_valid <= ext_rsp;
    ext_r_rdata <= ext_last ^ 32'hE0E0_E0E0;
    ext_r_opc   <= ext_last[2];
    pe_gnt      <= pe_cnt >= pe_dly;
    pe_r_valid  <= pe_rsp;
    pe_r_rdata  <= ~pe_last;
    pe_r_opc    <= pe_last[3];
  end

  // Routing, field and response checks
  always @(posedge clk) begin
    if (rst_ni) begin
      if (data_req) begin
        check_eq(sh_req_o, cur_dest == SH, "SH request strobe");
        check_eq(ext_req_o, cur_dest == EXT, "EXT request strobe");
        if (cur_dest != PE)
          check_eq(pe_req_o, 1'b0, "PE request strobe");
      end
      if (sh_req_o)
        check_eq({sh_addr_o, sh_wen_o, sh_wdata_o, sh_be_o},
                 {data_add, data_wen, data_wdata, data_be}, "SH request fields");
      if (ext_req_o)
        check_eq({ext_addr_o, ext_wen_o, ext_wdata_o, ext_be_o},
                 {data_add, data_wen, data_wdata, data_be}, "EXT request fields");
      if (pe_req_o)
        check_eq({pe_addr_o, pe_wen_o, pe_wdata_o, pe_be_o},
                 {data_add, data_wen, data_wdata, data_be}, "PE request fields");
      if (pe_gnt_q)
        check_eq(data_r_valid_o, 1'b1, "PE response one cycle after grant");
      if (data_r_valid_o) begin
        check_eq(exp_q.size() != 0, 1'b1, "response with no request open");
        check_eq({data_r_opc_o, data_r_rdata_o}, exp_q.pop_front(), "response opc and data");
      end
      if (data_req && data_gnt_o)
        exp_q.push_back(expected_resp(cur_dest, data_add));
      pe_gnt_q <= data_req && data_gnt_o && cur_dest == PE;
    end
  end

  initial begin
    void'($urandom(85748));
    rst_ni     = 1'b0;
    cluster_id = '0;
    data_req   = 1'b0;
    data_add   = '0;
    data_wen   = 1'b1;
    data_wdata = '0;
    data_be    = '0;
    repeat (4) @(negedge clk);
    rst_ni = 1'b1;
    @(posedge clk);
    check_eq({data_gnt_o, data_r_valid_o, sh_req_o, ext_req_o, pe_req_o}, '0,
             "outputs idle after reset");
    for (int i = 0; i < NumRows; i++) begin
      @(negedge clk);
      cur_dest   = Rows[i].dest;
      cluster_id = Rows[i].cid;
      data_req   = 1'b1;
      data_add   = Rows[i].addr;
      data_wen   = Rows[i].wen;
      data_wdata = Rows[i].wdata;
      data_be    = Rows[i].be;
      do @(posedge clk); while (!data_gnt_o);  // Core holds until granted
    end
    @(negedge clk);
    data_req = 1'b0;
    while (exp_q.size() != 0) @(negedge clk);
    $display("all tests passed");
    $finish;
  end

  // Watchdog sized by the table
  initial begin
    #(ClkPeriod * (NumRows * 40 + 8));
    $display("Error: %0t ns: run timed out waiting for the DUT", $time);
    $display("tests failed");
    $fatal(1, "watchdog expired");
  end

endmodule

/* core_demux.f */
+incdir+logic
logic/demux_map_pkg.sv
logic/demux_bus_pkg.sv
logic/addr_decoder.sv
logic/req_router.sv
logic/periph_fifo.sv
logic/periph_txn_ctrl.sv
logic/core_demux.sv
dv/core_demux_sva.sv
dv/core_demux_tb.sv

/* Makefile */
SRCS := core_demux.f $(wildcard logic/*.sv logic/*.svh dv/*.sv)

.PHONY: run clean

obj_dir/Vcore_demux_tb: $(SRCS)
	verilator --binary --assert -Wno-fatal --top-module core_demux_tb -f core_demux.f

sim.log: obj_dir/Vcore_demux_tb
	-./obj_dir/Vcore_demux_tb > sim.log 2>&1

run: sim.log
	@cat sim.log
	@! grep -q "tests failed" sim.log
	@grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
